//--- verif/sram_test_tests.txt
# mode sel addr0 din0 csb0 web0 wmask0 addr1 din1 csb1 web1 wmask1 fill capture
# fill 1 replaces both din fields with LFSR words, capture 1 pulses the capture strobe
LA   3 5 deadbeef 0 0 f 0 00000000 1 1 0 0 0
LA   3 5 00000000 0 1 0 0 00000000 1 1 0 0 1
# byte masked writes into bank 3 word 6
LA   3 6 11223344 0 0 f 0 00000000 1 1 0 0 0
LA   3 6 aabbccdd 0 0 5 0 00000000 1 1 0 0 0
LA   3 0 00000000 1 1 0 6 99000000 0 0 8 0 0
LA   3 6 00000000 0 1 0 5 00000000 0 1 0 0 1
# same addresses in another bank
LA   7 5 0badf00d 0 0 f 6 cafe0007 0 0 f 0 0
LA   7 5 00000000 0 1 0 6 00000000 0 1 0 0 1
LA   3 6 ffffffff 0 1 0 5 ffffffff 0 1 0 0 1
# both ports on one word
LA   c 9 aaaa5555 0 0 f 9 5555aaaa 0 0 f 0 0
LA   c 9 00000000 0 1 0 9 00000000 0 1 0 0 1
LA   c a 12345678 0 0 f a 87654321 0 0 3 0 0
LA   c a 00000000 0 1 0 9 00000000 0 1 0 0 1
# LFSR fill data
LA   0 0 00000000 0 0 f 1 00000000 0 0 f 1 0
LA   0 0 00000000 0 1 0 1 00000000 0 1 0 0 1
LA   f f 00000000 0 0 f e 00000000 0 0 f 1 0
LA   f f 00000000 0 1 0 e 00000000 0 1 0 0 1
# scanned commands
GPIO 5 2 13579bdf 0 0 f 0 00000000 1 1 0 0 0
GPIO 5 2 00000000 0 1 0 0 00000000 1 1 0 0 1
GPIO 5 0 00000000 1 1 0 2 0000aa00 0 0 2 0 0
GPIO 5 2 00000000 0 1 0 2 00000000 0 1 0 0 1
GPIO 9 4 00000000 0 0 f b 00000000 0 0 f 1 0
GPIO 9 4 00000000 0 1 0 b 00000000 0 1 0 0 1
GPIO 3 5 00000000 0 1 0 6 00000000 0 1 0 0 0
LA   5 2 00000000 0 1 0 3 5a5a5a5a 0 0 f 0 0
# memory after the scans
LA   3 5 00000000 0 1 0 6 00000000 0 1 0 0 1
LA   7 5 00000000 0 1 0 6 00000000 0 1 0 0 1
LA   c 9 00000000 0 1 0 a 00000000 0 1 0 0 1
LA   5 3 00000000 0 1 0 2 00000000 0 1 0 0 1
LA   0 1 00000000 0 1 0 0 00000000 0 1 0 0 1
LA   f e 00000000 0 1 0 f 00000000 0 1 0 0 1
GPIO 9 b 00000000 0 1 0 4 00000000 0 1 0 0 1

//--- filelist.f
design/sram_test_pkg.sv
design/sram_bank.sv
design/sram_test_ctrl.sv
design/sram_test_top.sv
verif/sram_test_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build with Verilator, run the testbench and judge the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --top-module sram_test_tb -f filelist.f -o sram_test_sim \
   || { echo "Verilator build failed"; exit 1; }
./obj_dir/sram_test_sim > sim.log 2>&1 || echo "Simulator exited with an error"
cat sim.log
grep -q ">>> FAIL" sim.log && { echo "Simulation failed"; exit 1; }
grep -q ">>> PASS" sim.log || { echo "No result found in sim.log"; exit 1; }
echo "Simulation passed"

//--- verif/sram_test_tb.sv
`timescale 1ns/1ns

module sram_test_tb;

   import sram_test_pkg::*;

   localparam int reset_cycles = 10;

   logic      clk = 1'b0;
   logic      resetn;
   logic      la_in_load;
   cmd_word_t la_data_in;
   logic      gpio_scan;
   logic      gpio_in;
   logic      la_sram_load;
   logic      gpio_sram_load;
   cmd_word_t la_data_out;
   logic      gpio_out;

   // Commands read from the data file
   cmd_word_t cmd_q[$];
   logic      gpio_q[$];
   logic      cap_q[$];
   logic      load_ok;

   // Reference model of the banks and of the command register
   sram_data_t model_mem [num_banks][mem_depth];
   sram_data_t model_dout0 [num_banks];
   sram_data_t model_dout1 [num_banks];
   cmd_word_t  model_reg;

   logic [15:0] lfsr_state = 16'd88;
   int cycle_count = 0;
   int cycle_limit = 0;
   int current_test = 0;
   int test_errors = 0;
   int failed_tests = 0;

   sram_test_top sram_test_top_inst (
      .clk            (clk),
      .resetn         (resetn),
      .la_in_load     (la_in_load),
      .la_data_in     (la_data_in),
      .gpio_scan      (gpio_scan),
      .gpio_in        (gpio_in),
      .la_sram_load   (la_sram_load),
      .gpio_sram_load (gpio_sram_load),
      .la_data_out    (la_data_out),
      .gpio_out       (gpio_out)
   );

   always #50 clk = ~clk;

   // Watchdog, limit is set once the data file is read
   always @(posedge clk) begin
      cycle_count <= cycle_count + 1;
      if (cycle_limit > 0 && cycle_count > cycle_limit) begin
         $display("Timeout: no result after %0d clock cycles", cycle_count);
         $display(">>> FAIL");
         $finish;
      end
   end

   // Galois LFSR, taps 0xB400
   function automatic logic [15:0] lfsr_step(input logic [15:0] state);
      if (state[0]) begin
         return (state >> 1) ^ 16'hB400;
      end
      return state >> 1;
   endfunction

   // One step per bit taken
   function automatic sram_data_t random_word();
      sram_data_t word;
      word = '0;
      for (int i = 0; i < data_size; i++) begin
         word = {word[data_size-2:0], lfsr_state[0]};
         lfsr_state = lfsr_step(lfsr_state);
      end
      return word;
   endfunction

   task automatic load_tests();
      int          fd;
      int          count;
      logic [31:0] mode;
      logic [8*160-1:0] rest;
      logic        done;
      bank_sel_t   sel;
      sram_addr_t  a0;
      sram_addr_t  a1;
      sram_data_t  d0;
      sram_data_t  d1;
      logic        c0;
      logic        c1;
      logic        w0;
      logic        w1;
      sram_wmask_t m0;
      sram_wmask_t m1;
      logic        fill;
      logic        cap;
      load_ok = 1'b1;
      done = 1'b0;
      fd = $fopen("verif/sram_test_tests.txt", "r");
      if (fd == 0) begin
         load_ok = 1'b0;
         done = 1'b1;
      end
      while (!done) begin
         count = $fscanf(fd, "%s", mode);
         if (count != 1) begin
            done = 1'b1;
         end else if (mode == {24'h0, "#"}) begin
            count = $fgets(rest, fd);
         end else begin
            count = $fscanf(fd, "%h %h %h %h %h %h %h %h %h %h %h %h %h",
                            sel, a0, d0, c0, w0, m0, a1, d1, c1, w1, m1, fill, cap);
            if (count != 13 || (mode != "GPIO" && mode != {16'h0, "LA"})) begin
               $display("Command %0d in the test file cannot be read", cmd_q.size() + 1);
               load_ok = 1'b0;
               done = 1'b1;
            end else begin
               if (fill) begin
                  d0 = random_word();
                  d1 = random_word();
               end
               cmd_q.push_back({sel, a0, d0, c0, w0, m0, a1, d1, c1, w1, m1});
               gpio_q.push_back(mode == "GPIO");
               cap_q.push_back(cap);
            end
         end
      end
      if (fd != 0) begin
         $fclose(fd);
      end
      if (cmd_q.size() == 0) begin
         load_ok = 1'b0;
      end
   endtask

   task automatic write_bytes(input bank_sel_t sel, input sram_addr_t addr,
                              input sram_data_t data, input sram_wmask_t wmask);
      for (int b = 0; b < wmask_size; b++) begin
         if (wmask[b]) begin
            model_mem[sel][addr][b*byte_size +: byte_size] = data[b*byte_size +: byte_size];
         end
      end
   endtask

   // One access edge of the selected bank
   task automatic model_access(input cmd_word_t cmd);
      bank_sel_t sel;
      sel = cmd[sel_lsb +: sel_size];
      // Reads see the memory as it was before this edge
      if (!cmd[p0_csb_bit] && cmd[p0_web_bit]) begin
         model_dout0[sel] = model_mem[sel][cmd[p0_addr_lsb +: addr_size]];
      end
      if (!cmd[p1_csb_bit] && cmd[p1_web_bit]) begin
         model_dout1[sel] = model_mem[sel][cmd[p1_addr_lsb +: addr_size]];
      end
      // Port 1 goes last and so wins a shared word
      if (!cmd[p0_csb_bit] && !cmd[p0_web_bit]) begin
         write_bytes(sel, cmd[p0_addr_lsb +: addr_size], cmd[p0_din_lsb +: data_size],
                     cmd[p0_wmask_lsb +: wmask_size]);
      end
      if (!cmd[p1_csb_bit] && !cmd[p1_web_bit]) begin
         write_bytes(sel, cmd[p1_addr_lsb +: addr_size], cmd[p1_din_lsb +: data_size],
                     cmd[p1_wmask_lsb +: wmask_size]);
      end
   endtask

   function automatic cmd_word_t captured(input cmd_word_t cmd);
      cmd_word_t word;
      bank_sel_t sel;
      word = cmd;
      sel = cmd[sel_lsb +: sel_size];
      word[p0_din_lsb +: data_size] = model_dout0[sel];
      word[p1_din_lsb +: data_size] = model_dout1[sel];
      return word;
   endfunction

   task automatic check_word(input string name, input cmd_word_t expected,
                             input cmd_word_t actual);
      if (actual !== expected) begin
         $display("[ERROR] test %0d %s expected %h got %h", current_test, name,
                  expected, actual);
         test_errors++;
      end
   endtask

   task automatic check_bit(input string name, input logic expected, input logic actual);
      if (actual !== expected) begin
         $display("[ERROR] test %0d %s expected %h got %h", current_test, name,
                  expected, actual);
         test_errors++;
      end
   endtask

   task automatic report_test(input string label);
      if (test_errors == 0) begin
         $display("test %0d (%s) passed", current_test, label);
      end else begin
         $display("test %0d (%s) failed with %0d errors", current_test, label, test_errors);
         failed_tests++;
      end
   endtask

   // Shifts a word in MSB first while the old contents come out on gpio_out
   // Called right after a rising edge and returns right after one
   task automatic scan_word(input cmd_word_t word_in, output cmd_word_t word_out);
      gpio_scan <= 1'b1;
      gpio_in   <= word_in[total_size-1];
      for (int i = 0; i < total_size; i++) begin
         @(negedge clk);
         word_out[total_size-1-i] = gpio_out;
         @(posedge clk);
         if (i < total_size - 1) begin
            gpio_in <= word_in[total_size-2-i];
         end else begin
            gpio_scan <= 1'b0;
            gpio_in   <= 1'b0;
         end
      end
   endtask

   task automatic reset_check();
      for (int b = 0; b < num_banks; b++) begin
         model_dout0[b] = '0;
         model_dout1[b] = '0;
         for (int a = 0; a < mem_depth; a++) begin
            model_mem[b][a] = '0;
         end
      end
      model_reg = '0;
      repeat (reset_cycles) @(posedge clk);
      resetn <= 1'b1;
      @(negedge clk);
      check_word("la_data_out", '0, la_data_out);
      check_bit("gpio_out", 1'b0, gpio_out);
      report_test("reset");
   endtask

   task automatic run_command(input int t);
      cmd_word_t cmd;
      cmd_word_t expected;
      cmd_word_t scanned;
      cmd = cmd_q[t];
      current_test = t + 1;
      test_errors = 0;
      @(posedge clk);
      if (gpio_q[t]) begin
         scan_word(cmd, scanned);
         check_word("gpio_out", model_reg, scanned);
         @(negedge clk);
         check_word("la_data_out", cmd, la_data_out);
         @(posedge clk);
         model_access(cmd);
         gpio_sram_load <= cap_q[t];
         @(posedge clk);
         gpio_sram_load <= 1'b0;
         expected = cap_q[t] ? captured(cmd) : cmd;
         // Scan-out feeds the word back in so the register ends unchanged
         scan_word(expected, scanned);
         check_word("gpio_out", expected, scanned);
         @(negedge clk);
         check_word("la_data_out", expected, la_data_out);
         report_test("GPIO");
      end else begin
         la_data_in <= cmd;
         la_in_load <= 1'b1;
         @(posedge clk);
         la_in_load <= 1'b0;
         @(negedge clk);
         check_word("la_data_out", cmd, la_data_out);
         @(posedge clk);
         model_access(cmd);
         la_sram_load <= cap_q[t];
         @(posedge clk);
         la_sram_load <= 1'b0;
         expected = cap_q[t] ? captured(cmd) : cmd;
         @(negedge clk);
         check_word("la_data_out", expected, la_data_out);
         report_test("LA");
      end
      model_reg = expected;
   endtask

   initial begin
      resetn         <= 1'b0;
      la_in_load     <= 1'b0;
      la_data_in     <= '0;
      gpio_scan      <= 1'b0;
      gpio_in        <= 1'b0;
      la_sram_load   <= 1'b0;
      gpio_sram_load <= 1'b0;
      load_tests();
      if (!load_ok) begin
         $display("The test file verif/sram_test_tests.txt could not be read");
         $display(">>> FAIL");
         $finish;
      end else begin
         cycle_limit = 2 * (cmd_q.size() * (2 * total_size + 4) + reset_cycles);
         reset_check();
         for (int t = 0; t < cmd_q.size(); t++) begin
            run_command(t);
         end
         $display("%0d tests run, %0d failed", cmd_q.size() + 1, failed_tests);
         if (failed_tests == 0) begin
            $display(">>> PASS");
         end else begin
            $display(">>> FAIL");
         end
         $finish;
      end
   end

endmodule

//--- design/sram_test_top.sv
`timescale 1ns/1ns

module sram_test_top (
   input  logic                     clk,
   input  logic                     resetn,
   input  logic                     la_in_load,
   input  sram_test_pkg::cmd_word_t la_data_in,
   input  logic                     gpio_scan,
   input  logic                     gpio_in,
   input  logic                     la_sram_load,
   input  logic                     gpio_sram_load,
   output sram_test_pkg::cmd_word_t la_data_out,
   output logic                     gpio_out
);

   import sram_test_pkg::*;

   // Shared SRAM bus
   sram_addr_t  addr0;
   sram_data_t  din0;
   logic        web0;
   sram_wmask_t wmask0;
   sram_addr_t  addr1;
   sram_data_t  din1;
   logic        web1;
   sram_wmask_t wmask1;
   bank_csb_t   csb0;
   bank_csb_t   csb1;

   logic [num_banks*data_size-1:0] bank_dout0;
   logic [num_banks*data_size-1:0] bank_dout1;

   sram_test_ctrl sram_test_ctrl_inst (
      .clk            (clk),
      .resetn         (resetn),
      .la_in_load     (la_in_load),
      .la_data_in     (la_data_in),
      .gpio_scan      (gpio_scan),
      .gpio_in        (gpio_in),
      .la_sram_load   (la_sram_load),
      .gpio_sram_load (gpio_sram_load),
      .bank_dout0     (bank_dout0),
      .bank_dout1     (bank_dout1),
      .addr0          (addr0),
      .din0           (din0),
      .web0           (web0),
      .wmask0         (wmask0),
      .addr1          (addr1),
      .din1           (din1),
      .web1           (web1),
      .wmask1         (wmask1),
      .csb0           (csb0),
      .csb1           (csb1),
      .la_data_out    (la_data_out),
      .gpio_out       (gpio_out)
   );

   // Each bank sees the shared bus and its own chip-select bits
   for (genvar i = 0; i < num_banks; i++) begin : g_bank
      sram_bank sram_bank_inst (
         .clk    (clk),
         .resetn (resetn),
         .csb0   (csb0[i]),
         .web0   (web0),
         .wmask0 (wmask0),
         .addr0  (addr0),
         .din0   (din0),
         .csb1   (csb1[i]),
         .web1   (web1),
         .wmask1 (wmask1),
         .addr1  (addr1),
         .din1   (din1),
         .dout0  (bank_dout0[i*data_size +: data_size]),
         .dout1  (bank_dout1[i*data_size +: data_size])
      );
   end

endmodule

//--- design/sram_test_ctrl.sv
`timescale 1ns/1ns

module sram_test_ctrl (
   input  logic                       clk,
   input  logic                       resetn,
   input  logic                       la_in_load,
   input  sram_test_pkg::cmd_word_t   la_data_in,
   input  logic                       gpio_scan,
   input  logic                       gpio_in,
   input  logic                       la_sram_load,
   input  logic                       gpio_sram_load,
   // Read words of every bank, bank i at slice i
   input  logic [sram_test_pkg::num_banks*sram_test_pkg::data_size-1:0] bank_dout0,
   input  logic [sram_test_pkg::num_banks*sram_test_pkg::data_size-1:0] bank_dout1,
   output sram_test_pkg::sram_addr_t  addr0,
   output sram_test_pkg::sram_data_t  din0,
   output logic                       web0,
   output sram_test_pkg::sram_wmask_t wmask0,
   output sram_test_pkg::sram_addr_t  addr1,
   output sram_test_pkg::sram_data_t  din1,
   output logic                       web1,
   output sram_test_pkg::sram_wmask_t wmask1,
   output sram_test_pkg::bank_csb_t   csb0,
   output sram_test_pkg::bank_csb_t   csb1,
   output sram_test_pkg::cmd_word_t   la_data_out,
   output logic                       gpio_out
);

   import sram_test_pkg::*;

   cmd_word_t  cmd_reg;
   cmd_word_t  capture_word;
   bank_sel_t  bank_sel;
   logic       port0_csb;
   logic       port1_csb;
   logic       capture;
   sram_data_t read_data0;
   sram_data_t read_data1;

   assign capture = la_sram_load || gpio_sram_load;

   // Command register
   // scan beats parallel load, which beats capture
   always_ff @(posedge clk) begin
      if (!resetn) begin
         cmd_reg <= '0;
      end else if (gpio_scan) begin
         cmd_reg <= {cmd_reg[total_size-2:0], gpio_in};
      end else if (la_in_load) begin
         cmd_reg <= la_data_in;
      end else if (capture) begin
         cmd_reg <= capture_word;
      end
   end

   // Field split
   assign bank_sel  = cmd_reg[sel_lsb +: sel_size];

   assign addr0     = cmd_reg[p0_addr_lsb +: addr_size];
   assign din0      = cmd_reg[p0_din_lsb +: data_size];
   assign port0_csb = cmd_reg[p0_csb_bit];
   assign web0      = cmd_reg[p0_web_bit];
   assign wmask0    = cmd_reg[p0_wmask_lsb +: wmask_size];

   assign addr1     = cmd_reg[p1_addr_lsb +: addr_size];
   assign din1      = cmd_reg[p1_din_lsb +: data_size];
   assign port1_csb = cmd_reg[p1_csb_bit];
   assign web1      = cmd_reg[p1_web_bit];
   assign wmask1    = cmd_reg[p1_wmask_lsb +: wmask_size];

   // One-hot active-low chip selects
   // Nothing reaches memory while in reset or while bits are shifting through
   always_comb begin
      csb0 = '1;
      csb1 = '1;
      if (resetn && !gpio_scan) begin
         csb0[bank_sel] = port0_csb;
         csb1[bank_sel] = port1_csb;
      end
   end

   // Read mux, selected bank only
   assign read_data0 = bank_dout0[bank_sel*data_size +: data_size];
   assign read_data1 = bank_dout1[bank_sel*data_size +: data_size];

   // Capture overwrites only the two din fields
   always_comb begin
      capture_word = cmd_reg;
      capture_word[p0_din_lsb +: data_size] = read_data0;
      capture_word[p1_din_lsb +: data_size] = read_data1;
   end

   assign la_data_out = cmd_reg;
   assign gpio_out    = cmd_reg[total_size-1];  // scan-out is MSB first

endmodule

//--- design/sram_bank.sv
`timescale 1ns/1ns

module sram_bank (
   input  logic                      clk,
   input  logic                      resetn,
   input  logic                      csb0,
   input  logic                      web0,
   input  sram_test_pkg::sram_wmask_t wmask0,
   input  sram_test_pkg::sram_addr_t  addr0,
   input  sram_test_pkg::sram_data_t  din0,
   input  logic                      csb1,
   input  logic                      web1,
   input  sram_test_pkg::sram_wmask_t wmask1,
   input  sram_test_pkg::sram_addr_t  addr1,
   input  sram_test_pkg::sram_data_t  din1,
   output sram_test_pkg::sram_data_t  dout0,
   output sram_test_pkg::sram_data_t  dout1
);

   import sram_test_pkg::*;

   sram_data_t mem [0:mem_depth-1];

   // Byte-masked writes from both ports
   // Port 1 is applied last so it wins on a shared word
   always_ff @(posedge clk) begin
      if (!csb0 && !web0) begin
         for (int b = 0; b < wmask_size; b++) begin
            if (wmask0[b]) begin
               mem[addr0][b*byte_size +: byte_size] <= din0[b*byte_size +: byte_size];
            end
         end
      end
      if (!csb1 && !web1) begin
         for (int b = 0; b < wmask_size; b++) begin
            if (wmask1[b]) begin
               mem[addr1][b*byte_size +: byte_size] <= din1[b*byte_size +: byte_size];
            end
         end
      end
   end

   // Registered read ports, hold their value on a write or idle cycle
   always_ff @(posedge clk) begin
      if (!resetn) begin
         dout0 <= '0;
         dout1 <= '0;
      end else begin
         if (!csb0 && web0) begin
            dout0 <= mem[addr0];
         end
         if (!csb1 && web1) begin
            dout1 <= mem[addr1];
         end
      end
   end

endmodule

//--- design/sram_test_pkg.sv
package sram_test_pkg;

   // Array geometry
   localparam int num_banks  = 16;
   localparam int sel_size   = 4;
   localparam int addr_size  = 4;
   localparam int mem_depth  = 1 << addr_size;
   localparam int data_size  = 32;
   localparam int wmask_size = 4;
   localparam int byte_size  = data_size / wmask_size;

   // One port is address, data-in, csb, web and wmask
   localparam int port_size  = addr_size + data_size + 2 + wmask_size;
   localparam int total_size = sel_size + 2 * port_size;

   // Command register field positions, MSB down
   localparam int sel_lsb      = 84;
   localparam int p0_addr_lsb  = 80;
   localparam int p0_din_lsb   = 48;
   localparam int p0_csb_bit   = 47;
   localparam int p0_web_bit   = 46;
   localparam int p0_wmask_lsb = 42;
   localparam int p1_addr_lsb  = 38;
   localparam int p1_din_lsb   = 6;
   localparam int p1_csb_bit   = 5;
   localparam int p1_web_bit   = 4;
   localparam int p1_wmask_lsb = 0;

   typedef logic [sel_size-1:0]   bank_sel_t;
   typedef logic [addr_size-1:0]  sram_addr_t;
   typedef logic [data_size-1:0]  sram_data_t;
   typedef logic [wmask_size-1:0] sram_wmask_t;

   // Active-low chip selects, bit i for bank i
   typedef logic [num_banks-1:0]  bank_csb_t;

   typedef logic [total_size-1:0] cmd_word_t;

endpackage
